// File: reservation_station.f
src/isa_pkg.sv
src/rs_pkg.sv
src/cdb_if.sv
src/rs_entry.sv
src/rs_arbiter.sv
src/reservation_station.sv
testbench/reservation_station_asserts.sv
testbench/reservation_station_tb.sv

// File: Makefile
# Verilator build and run of the reservation station testbench

OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --assert -j 0 --top-module reservation_station_tb \
		-f reservation_station.f -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/Vreservation_station_tb | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/reservation_station_tb.sv
////////////////////
// testbench for the reservation station
// directed and random dispatch, wakeup and stall runs checked against a model
////////////////////

module reservation_station_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import isa_pkg::*;
   import rs_pkg::*;

   localparam int NUM_ENTRIES = 8;
   localparam int TIMEOUT     = 200;

   typedef struct {
      alu_op_t op;
      tag_t    dest;
      tag_t    tag_a;
      tag_t    tag_b;
      value_t  value_a;
      value_t  value_b;
   } entry_t;

   logic    clock;
   logic    reset;
   logic    in_valid;
   logic    in_ready;
   alu_op_t in_op;
   tag_t    in_dest_tag;
   tag_t    in_tag_a;
   value_t  in_value_a;
   tag_t    in_tag_b;
   value_t  in_value_b;
   tag_t    cdb1_tag;
   value_t  cdb1_value;
   tag_t    cdb2_tag;
   value_t  cdb2_value;
   logic    out_valid;
   logic    out_ready;
   alu_op_t out_op;
   tag_t    out_dest_tag;
   value_t  out_value_a;
   value_t  out_value_b;

   // model of the occupied entries, oldest first
   entry_t model [$];
   string  test_name;
   int     errors;
   int     errors_at_start;
   int     tests_run;
   int     tests_failed;
   int     issue_count;
   int     cycles;
   int     seed = 32'hfb784a97;

   reservation_station #(.NUM_ENTRIES(NUM_ENTRIES)) uut (.*);

   always #10 clock = ~clock;

   ////////////////////
   // reference model
   ////////////////////

   function automatic tag_t woken_tag(tag_t tag);
      if (tag != TAG_NULL && (tag == cdb1_tag || tag == cdb2_tag))
         return TAG_NULL;
      return tag;
   endfunction

   // cdb1 wins when both buses carry the tag
   function automatic value_t woken_value(tag_t tag, value_t held);
      if (tag != TAG_NULL && tag == cdb1_tag)
         return cdb1_value;
      if (tag != TAG_NULL && tag == cdb2_tag)
         return cdb2_value;
      return held;
   endfunction

   function automatic entry_t wake_entry(entry_t e);
      e.value_a = woken_value(e.tag_a, e.value_a);
      e.tag_a   = woken_tag(e.tag_a);
      e.value_b = woken_value(e.tag_b, e.value_b);
      e.tag_b   = woken_tag(e.tag_b);
      return e;
   endfunction

   // position of the next instruction to issue, -1 when nothing is ready
   function automatic int expected_issue();
      foreach (model[i])
         if (model[i].tag_a == TAG_NULL && model[i].tag_b == TAG_NULL)
            return i;
      return -1;
   endfunction

   task automatic report_mismatch(input string what, input logic [63:0] expected,
                                  input logic [63:0] actual);
      $display("ERROR %s: %s expected %h actual %h", test_name, what, expected, actual);
      errors++;
   endtask

   task automatic report_failure(input string what);
      $display("%s: %s", test_name, what);
      errors++;
   endtask

   // outputs and inputs are both settled at the falling edge
   always @(negedge clock)
   begin : compare
      int     pick;
      entry_t e;
      if (!reset)
      begin
         pick = expected_issue();
         if (out_valid !== (pick >= 0))
            report_mismatch("out_valid", 64'(pick >= 0), 64'(out_valid));
         if (in_ready !== (model.size() < NUM_ENTRIES))
            report_mismatch("in_ready", 64'(model.size() < NUM_ENTRIES), 64'(in_ready));
         if (out_valid && out_ready && pick >= 0)
         begin
            e = model[pick];
            if (out_op !== e.op)
               report_mismatch("out_op", 64'(e.op), 64'(out_op));
            if (out_dest_tag !== e.dest)
               report_mismatch("out_dest_tag", 64'(e.dest), 64'(out_dest_tag));
            if (out_value_a !== e.value_a)
               report_mismatch("out_value_a", e.value_a, out_value_a);
            if (out_value_b !== e.value_b)
               report_mismatch("out_value_b", e.value_b, out_value_b);
            model.delete(pick);
            issue_count++;
         end
         foreach (model[i])
            model[i] = wake_entry(model[i]);
         if (in_valid && in_ready)
         begin
            e = '{in_op, in_dest_tag, in_tag_a, in_tag_b, in_value_a, in_value_b};
            model.push_back(wake_entry(e));
         end
      end
   end

   ////////////////////
   // stimulus helpers
   ////////////////////

   task automatic step();
      @(posedge clock);
      #2;
   endtask

   task automatic dispatch(input alu_op_t op, input tag_t dest, input tag_t tag_a,
                           input value_t value_a, input tag_t tag_b, input value_t value_b);
      int waited;
      waited      = 0;
      in_valid    = 1'b1;
      in_op       = op;
      in_dest_tag = dest;
      in_tag_a    = tag_a;
      in_value_a  = value_a;
      in_tag_b    = tag_b;
      in_value_b  = value_b;
      @(negedge clock);
      while (!in_ready && waited < TIMEOUT)
      begin
         @(negedge clock);
         waited++;
      end
      if (!in_ready)
         report_failure("dispatch was never accepted");
      step();
      in_valid = 1'b0;
   endtask

   // empties the station, sweeping broadcasts over the small tags
   task automatic drain(output int taken);
      taken     = 0;
      out_ready = 1'b1;
      while (model.size() != 0 && taken < TIMEOUT)
      begin
         cdb1_tag   = tag_t'(taken % 16);
         cdb1_value = {$random(seed), $random(seed)};
         step();
         taken++;
      end
      cdb1_tag = TAG_NULL;
      if (model.size() != 0)
         report_failure("station did not drain in time");
   endtask

   task automatic start_test(input string name);
      test_name       = name;
      errors_at_start = errors;
   endtask

   task automatic end_test();
      tests_run++;
      if (errors == errors_at_start)
         $display("test %s: ok", test_name);
      else
      begin
         tests_failed++;
         $display("test %s: failed with %0d errors", test_name, errors - errors_at_start);
      end
   endtask

   ////////////////////
   // test sequence
   ////////////////////

   initial
   begin
      clock       = 1'b0;
      reset       = 1'b1;
      in_valid    = 1'b0;
      in_op       = ADD;
      in_dest_tag = '0;
      in_tag_a    = TAG_NULL;
      in_value_a  = '0;
      in_tag_b    = TAG_NULL;
      in_value_b  = '0;
      cdb1_tag    = TAG_NULL;
      cdb1_value  = '0;
      cdb2_tag    = TAG_NULL;
      cdb2_value  = '0;
      out_ready   = 1'b0;
      repeat (4) @(posedge clock);
      #2;
      reset = 1'b0;

      start_test("after_reset");
      @(negedge clock);
      if (out_valid !== 1'b0)
         report_mismatch("out_valid", 64'(0), 64'(out_valid));
      if (in_ready !== 1'b1)
         report_mismatch("in_ready", 64'(1), 64'(in_ready));
      step();
      end_test();

      start_test("resolved_operands");
      out_ready = 1'b1;
      dispatch(SUB, 8'h21, TAG_NULL, 64'h1234_5678_9abc_def0, TAG_NULL, 64'h0fed_cba9_8765_4321);
      cycles = issue_count;
      step();
      if (issue_count != cycles + 1)
         report_failure("instruction was not issued in the cycle after dispatch");
      end_test();

      start_test("cdb_wakeup");
      dispatch(AND, 8'h30, 8'h05, 64'hdead, 8'h06, 64'hbeef);
      cdb2_tag   = 8'h05;
      cdb2_value = 64'h5555;
      step();
      cdb1_tag   = 8'h06;
      cdb1_value = 64'h1111;
      cdb2_tag   = 8'h06;
      cdb2_value = 64'h2222;
      step();
      // broadcast lands in the dispatch cycle itself
      cdb1_tag   = 8'h07;
      cdb1_value = 64'h7777;
      cdb2_tag   = TAG_NULL;
      dispatch(XOR, 8'h31, 8'h07, 64'h0, TAG_NULL, 64'h42);
      cdb1_tag = TAG_NULL;
      drain(cycles);
      end_test();

      start_test("oldest_first");
      out_ready = 1'b0;
      for (int i = 0; i < 4; i++)
         dispatch(alu_op_t'(i), tag_t'(8'h40 + i), tag_t'(8'h10 + i), 64'h0, TAG_NULL, 64'(i));
      for (int i = 3; i >= 0; i--)
      begin
         cdb1_tag   = tag_t'(8'h10 + i);
         cdb1_value = 64'(100 + i);
         step();
      end
      cdb1_tag = TAG_NULL;
      drain(cycles);
      if (cycles != 4)
         report_mismatch("drain cycles", 64'(4), 64'(cycles));
      end_test();

      start_test("full_station");
      out_ready = 1'b0;
      for (int i = 0; i < NUM_ENTRIES; i++)
         dispatch(OR, tag_t'(8'h50 + i), TAG_NULL, 64'(i), TAG_NULL, 64'(i * 3));
      in_valid    = 1'b1;
      in_dest_tag = 8'h5f;
      repeat (3) step();
      if (in_ready !== 1'b0)
         report_mismatch("in_ready", 64'(0), 64'(in_ready));
      in_valid  = 1'b0;
      out_ready = 1'b1;
      step();
      out_ready = 1'b0;
      if (in_ready !== 1'b1)
         report_mismatch("in_ready", 64'(1), 64'(in_ready));
      drain(cycles);
      end_test();

      start_test("random_mix");
      for (int n = 0; n < 400; n++)
      begin
         in_valid    = 1'($random(seed));
         in_op       = alu_op_t'($random(seed) & 7);
         in_dest_tag = tag_t'($random(seed));
         in_tag_a    = (($random(seed) & 3) == 0) ? TAG_NULL : tag_t'($random(seed) & 15);
         in_tag_b    = (($random(seed) & 3) == 0) ? TAG_NULL : tag_t'($random(seed) & 15);
         in_value_a  = {$random(seed), $random(seed)};
         in_value_b  = {$random(seed), $random(seed)};
         cdb1_tag    = 1'($random(seed)) ? tag_t'($random(seed) & 15) : TAG_NULL;
         cdb1_value  = {$random(seed), $random(seed)};
         cdb2_tag    = 1'($random(seed)) ? tag_t'($random(seed) & 15) : TAG_NULL;
         cdb2_value  = {$random(seed), $random(seed)};
         out_ready   = (($random(seed) & 3) != 0);
         step();
      end
      in_valid = 1'b0;
      cdb2_tag = TAG_NULL;
      drain(cycles);
      end_test();

      $display("tests %0d, failed %0d, issues %0d, errors %0d",
               tests_run, tests_failed, issue_count, errors);
      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

// File: testbench/reservation_station_asserts.sv
////////////////////
// handshake assertions for the reservation station
// bound to every reservation_station instance
////////////////////

module reservation_station_asserts
#(
   parameter int NUM_ENTRIES = 8
)
(
   input logic                           clock,
   input logic                           reset,
   input logic                           in_valid,
   input logic                           in_ready,
   input logic                           out_valid,
   input logic                           out_ready,
   input logic [NUM_ENTRIES-1:0]         fill,
   input logic [$clog2(NUM_ENTRIES)-1:0] issue_index,
   input isa_pkg::alu_op_t               out_op,
   input rs_pkg::tag_t                   out_dest_tag,
   input isa_pkg::value_t                out_value_a,
   input isa_pkg::value_t                out_value_b
);
   timeunit 1ns;
   timeprecision 100ps;

   empty_after_reset: assert property (@(posedge clock) reset |=> !out_valid)
      else $error("out_valid high right after reset");

   // a stalled entry keeps its fields until an older one takes the slot
   stall_holds_fields: assert property (@(posedge clock) disable iff (reset)
      (out_valid && !out_ready) |=> (out_valid && (!$stable(issue_index) ||
         $stable({out_op, out_dest_tag, out_value_a, out_value_b}))))
      else $error("issue fields changed under back-pressure");

   // exactly one entry fills on a dispatch transfer and none otherwise
   single_fill: assert property (@(posedge clock) disable iff (reset)
      $onehot0(fill) && ((|fill) == (in_valid && in_ready)))
      else $error("entry fills do not match the dispatch handshake");

endmodule

bind reservation_station reservation_station_asserts #(
   .NUM_ENTRIES (NUM_ENTRIES)
) u_asserts (
   .clock        (clock),
   .reset        (reset),
   .in_valid     (in_valid),
   .in_ready     (in_ready),
   .out_valid    (out_valid),
   .out_ready    (out_ready),
   .fill         (fill),
   .issue_index  (issue_index),
   .out_op       (out_op),
   .out_dest_tag (out_dest_tag),
   .out_value_a  (out_value_a),
   .out_value_b  (out_value_b)
);

// File: src/reservation_station.sv
////////////////////
// reservation station top level
// dispatch in by valid/ready, one oldest-ready issue per cycle out by valid/ready
////////////////////

module reservation_station
#(
   parameter int NUM_ENTRIES = 8
)
(
   input  logic             clock,
   input  logic             reset,

   // dispatch side
   input  logic             in_valid,
   output logic             in_ready,
   input  isa_pkg::alu_op_t in_op,
   input  rs_pkg::tag_t     in_dest_tag,
   input  rs_pkg::tag_t     in_tag_a,
   input  isa_pkg::value_t  in_value_a,
   input  rs_pkg::tag_t     in_tag_b,
   input  isa_pkg::value_t  in_value_b,

   // result broadcasts
   input  rs_pkg::tag_t     cdb1_tag,
   input  isa_pkg::value_t  cdb1_value,
   input  rs_pkg::tag_t     cdb2_tag,
   input  isa_pkg::value_t  cdb2_value,

   // issue side
   output logic             out_valid,
   input  logic             out_ready,
   output isa_pkg::alu_op_t out_op,
   output rs_pkg::tag_t     out_dest_tag,
   output isa_pkg::value_t  out_value_a,
   output isa_pkg::value_t  out_value_b
);
   import isa_pkg::*;
   import rs_pkg::*;

   localparam int INDEX_WIDTH = $clog2(NUM_ENTRIES);

   logic [NUM_ENTRIES-1:0] fill;
   logic [NUM_ENTRIES-1:0] issue;
   logic [INDEX_WIDTH-1:0] issue_index;
   logic                   dispatch_taken;

   // per-entry state seen by the arbiter and the issue mux
   rs_status_t entry_status   [NUM_ENTRIES];
   age_t       entry_age      [NUM_ENTRIES];
   alu_op_t    entry_op       [NUM_ENTRIES];
   tag_t       entry_dest_tag [NUM_ENTRIES];
   value_t     entry_value_a  [NUM_ENTRIES];
   value_t     entry_value_b  [NUM_ENTRIES];

   cdb_if cdb ();

   assign cdb.cdb1_tag   = cdb1_tag;
   assign cdb.cdb1_value = cdb1_value;
   assign cdb.cdb2_tag   = cdb2_tag;
   assign cdb.cdb2_value = cdb2_value;

   // every occupied entry ages when any dispatch lands
   assign dispatch_taken = |fill;

   ////////////////////
   // entries
   ////////////////////

   for (genvar i = 0; i < NUM_ENTRIES; i++)
   begin : g_entry
      rs_entry u_entry
      (
         .clock          (clock),
         .reset          (reset),
         .fill           (fill[i]),
         .issue          (issue[i]),
         .dispatch_taken (dispatch_taken),
         .in_op          (in_op),
         .in_dest_tag    (in_dest_tag),
         .in_tag_a       (in_tag_a),
         .in_tag_b       (in_tag_b),
         .in_value_a     (in_value_a),
         .in_value_b     (in_value_b),
         .cdb            (cdb.sink),
         .status         (entry_status[i]),
         .age            (entry_age[i]),
         .op             (entry_op[i]),
         .dest_tag       (entry_dest_tag[i]),
         .value_a        (entry_value_a[i]),
         .value_b        (entry_value_b[i])
      );
   end

   ////////////////////
   // selection
   ////////////////////

   rs_arbiter #(
      .NUM_ENTRIES (NUM_ENTRIES)
   ) u_arbiter (
      .status      (entry_status),
      .age         (entry_age),
      .in_valid    (in_valid),
      .out_ready   (out_ready),
      .in_ready    (in_ready),
      .out_valid   (out_valid),
      .fill        (fill),
      .issue       (issue),
      .issue_index (issue_index)
   );

   // issue fields of the chosen entry
   assign out_op       = entry_op[issue_index];
   assign out_dest_tag = entry_dest_tag[issue_index];
   assign out_value_a  = entry_value_a[issue_index];
   assign out_value_b  = entry_value_b[issue_index];

endmodule

// File: src/rs_arbiter.sv
////////////////////
// allocation and issue selection for the station, purely combinational
// fills the lowest free entry, issues the oldest ready one
////////////////////

module rs_arbiter
#(
   parameter int NUM_ENTRIES = 8
)
(
   input  rs_pkg::rs_status_t           status [NUM_ENTRIES],
   input  rs_pkg::age_t                 age    [NUM_ENTRIES],
   input  logic                         in_valid,
   input  logic                         out_ready,
   output logic                         in_ready,
   output logic                         out_valid,
   output logic [NUM_ENTRIES-1:0]       fill,
   output logic [NUM_ENTRIES-1:0]       issue,
   output logic [$clog2(NUM_ENTRIES)-1:0] issue_index
);
   import rs_pkg::*;

   localparam int INDEX_WIDTH = $clog2(NUM_ENTRIES);

   logic [NUM_ENTRIES-1:0] free;
   logic [NUM_ENTRIES-1:0] ready;
   logic [NUM_ENTRIES-1:0] alloc;
   logic [NUM_ENTRIES-1:0] oldest;

   ////////////////////
   // allocation
   ////////////////////

   always_comb
   begin
      alloc = '0;
      for (int i = NUM_ENTRIES - 1; i >= 0; i--)
      begin
         free[i] = (status[i] == EMPTY);
         if (free[i])
            alloc = NUM_ENTRIES'(1) << i;
      end
      in_ready = |free;
      fill     = in_valid ? alloc : '0;
   end

   ////////////////////
   // oldest ready entry
   ////////////////////

   // entry i wins if it beats every other ready entry, ties go to the lower index
   always_comb
   begin
      for (int i = 0; i < NUM_ENTRIES; i++)
         ready[i] = (status[i] == READY);

      issue_index = '0;
      for (int i = 0; i < NUM_ENTRIES; i++)
      begin
         oldest[i] = ready[i];
         for (int j = 0; j < NUM_ENTRIES; j++)
         begin
            if (j != i && ready[j])
            begin
               if (age[j] > age[i] || (age[j] == age[i] && j < i))
                  oldest[i] = 1'b0;
            end
         end
         if (oldest[i])
            issue_index = INDEX_WIDTH'(i);
      end

      out_valid = |ready;
      issue     = out_ready ? oldest : '0;
   end

endmodule

// File: src/rs_entry.sv
////////////////////
// one reservation station entry
// holds an instruction, captures operands from the CDBs and tracks its age
////////////////////

module rs_entry
(
   input  logic               clock,
   input  logic               reset,
   input  logic               fill,
   input  logic               issue,
   input  logic               dispatch_taken,
   input  isa_pkg::alu_op_t   in_op,
   input  rs_pkg::tag_t       in_dest_tag,
   input  rs_pkg::tag_t       in_tag_a,
   input  rs_pkg::tag_t       in_tag_b,
   input  isa_pkg::value_t    in_value_a,
   input  isa_pkg::value_t    in_value_b,
   cdb_if.sink                cdb,
   output rs_pkg::rs_status_t status,
   output rs_pkg::age_t       age,
   output isa_pkg::alu_op_t   op,
   output rs_pkg::tag_t       dest_tag,
   output isa_pkg::value_t    value_a,
   output isa_pkg::value_t    value_b
);
   import isa_pkg::*;
   import rs_pkg::*;

   // outstanding producer tags, TAG_NULL once the value is held
   tag_t       tag_a;
   tag_t       tag_b;

   tag_t       next_tag_a;
   tag_t       next_tag_b;
   value_t     next_value_a;
   value_t     next_value_b;
   rs_status_t next_status;

   // cdb1 has priority when both buses carry the same tag
   function automatic void wake_operand
   (
      input  tag_t   tag,
      input  value_t value,
      output tag_t   woken_tag,
      output value_t woken_value
   );
      logic hit1;
      logic hit2;
      hit1 = (tag != TAG_NULL) && (tag == cdb.cdb1_tag);
      hit2 = (tag != TAG_NULL) && (tag == cdb.cdb2_tag);
      woken_tag = (hit1 || hit2) ? TAG_NULL : tag;
      if (hit1)
         woken_value = cdb.cdb1_value;
      else if (hit2)
         woken_value = cdb.cdb2_value;
      else
         woken_value = value;
   endfunction

   ////////////////////
   // operand wakeup
   ////////////////////

   // a fill is woken in the same cycle as the stored operands would be
   always_comb
   begin
      if (fill)
      begin
         wake_operand(in_tag_a, in_value_a, next_tag_a, next_value_a);
         wake_operand(in_tag_b, in_value_b, next_tag_b, next_value_b);
      end
      else
      begin
         wake_operand(tag_a, value_a, next_tag_a, next_value_a);
         wake_operand(tag_b, value_b, next_tag_b, next_value_b);
      end

      if (issue || (!fill && status == EMPTY))
         next_status = EMPTY;
      else
      begin
         case ({next_tag_a != TAG_NULL, next_tag_b != TAG_NULL})
            2'b00:   next_status = READY;
            2'b01:   next_status = WAITING_B;
            2'b10:   next_status = WAITING_A;
            default: next_status = WAITING_BOTH;
         endcase
      end
   end

   ////////////////////
   // state registers
   ////////////////////

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         status <= EMPTY;
         tag_a  <= TAG_NULL;
         tag_b  <= TAG_NULL;
         age    <= '0;
      end
      else
      begin
         status <= next_status;
         tag_a  <= next_tag_a;
         tag_b  <= next_tag_b;
         if (fill)
            age <= '0;
         else if (dispatch_taken && status != EMPTY && age != AGE_MAX)
            age <= age + 1'b1;
      end
   end

   // instruction payload
   always_ff @(posedge clock)
   begin
      if (fill)
      begin
         op       <= in_op;
         dest_tag <= in_dest_tag;
      end
      value_a <= next_value_a;
      value_b <= next_value_b;
   end

endmodule

// File: src/cdb_if.sv
////////////////////
// both common data buses as one bundle
// the top level drives source, every station entry listens on sink
////////////////////

interface cdb_if;
   import isa_pkg::*;
   import rs_pkg::*;

   // a bus with TAG_NULL carries nothing this cycle
   tag_t   cdb1_tag;
   value_t cdb1_value;
   tag_t   cdb2_tag;
   value_t cdb2_value;

   modport source (output cdb1_tag, output cdb1_value, output cdb2_tag, output cdb2_value);

   modport sink (input cdb1_tag, input cdb1_value, input cdb2_tag, input cdb2_value);

endinterface

// File: src/rs_pkg.sv
////////////////////
// reservation station types: producer tags, entry status and entry age
// import in any block that handles tags or station entries
////////////////////

package rs_pkg;

   localparam int TAG_WIDTH = 8;
   localparam int AGE_WIDTH = 8;

   typedef logic [TAG_WIDTH-1:0] tag_t;

   // all ones means no producer, so the operand already holds its value
   // and a CDB carrying it is idle
   localparam tag_t TAG_NULL = '1;

   // entry state, waiting states name the operands still outstanding
   typedef enum logic [2:0]
   {
      EMPTY        = 3'b000,
      WAITING_A    = 3'b001,
      WAITING_B    = 3'b010,
      WAITING_BOTH = 3'b011,
      READY        = 3'b100
   } rs_status_t;

   // dispatches seen since fill, saturates at the top
   typedef logic [AGE_WIDTH-1:0] age_t;

   localparam age_t AGE_MAX = '1;

endpackage

// File: src/isa_pkg.sv
////////////////////
// datapath types shared by the reservation station and the execute stage
// import where operand values or ALU opcodes are carried
////////////////////

package isa_pkg;

   // operand and result width
   localparam int VALUE_WIDTH = 64;

   typedef logic [VALUE_WIDTH-1:0] value_t;

   // ALU function codes, carried through the station unchanged
   typedef enum logic [4:0]
   {
      ADD   = 5'd0,
      SUB   = 5'd1,
      AND   = 5'd2,
      OR    = 5'd3,
      XOR   = 5'd4,
      SLL   = 5'd5,
      SRL   = 5'd6,
      CMPEQ = 5'd7
   } alu_op_t;

endpackage
